/* rtl/muldiv_pkg.sv */
// shared types and constants for the M-extension reservation station
// imported by every RTL file and the testbench
`default_nettype none

package muldiv_pkg;

  // data width and derived sizes
  localparam int xlen = 32;
  localparam int dxlen = 2 * xlen;
  // iteration counter width for the sequential units
  localparam int step_w = $clog2(xlen);

  typedef logic [xlen-1:0] word_t;
  // full multiplier product
  typedef logic [dxlen-1:0] dword_t;
  typedef logic [2:0] funct3_t;

  // RV32M funct3 encodings, signed DIV/REM not supported
  localparam funct3_t mul_funct3 = 3'd0;
  localparam funct3_t mulh_funct3 = 3'd1;
  localparam funct3_t mulhsu_funct3 = 3'd2;
  localparam funct3_t mulhu_funct3 = 3'd3;
  localparam funct3_t divu_funct3 = 3'd5;
  localparam funct3_t remu_funct3 = 3'd7;

  // operand signedness seen by the multiplier
  typedef enum logic [1:0] {
    mul_signed_signed,
    mul_signed_unsigned,
    mul_unsigned_unsigned
  } mul_mode_t;

  // multiplier ops all have funct3[2] clear
  function automatic logic is_mul_op(input funct3_t funct3);
    return ~funct3[2];
  endfunction

endpackage

`default_nettype wire

/* rtl/exec_if.sv */
// launch channel from the station to the mul/div unit
// station drives the operation, unit answers with busy and done
`default_nettype none

interface exec_if
  import muldiv_pkg::*;
#(
  parameter int rob_tag_w = 3
);

  // one-cycle launch pulse
  logic start;
  // operation fields, held stable until done
  funct3_t funct3;
  word_t a;
  word_t b;
  logic [rob_tag_w-1:0] tag;
  // unit status
  logic busy;
  logic done;

  modport station (output start, funct3, a, b, tag, input busy, done);
  modport unit (input start, funct3, a, b, tag, output busy, done);

endinterface

`default_nettype wire

/* rtl/seq_multiplier.sv */
// sequential shift-add multiplier, one multiplier bit per cycle
// 32 iterations after start, then a done pulse with the 64-bit product
`default_nettype none

module seq_multiplier
  import muldiv_pkg::*;
(
  input  logic      clk,
  input  logic      reset,
  input  logic      flush,
  input  logic      start,
  input  mul_mode_t mode,
  input  word_t     a,
  input  word_t     b,
  output dword_t    product,
  output logic      done
);

  logic running;
  logic [step_w-1:0] step;
  // multiplicand, extended and shifted left each step
  dword_t mcand;
  // multiplier bits, consumed from the bottom
  word_t mplier;
  logic b_signed;
  logic last_step;
  dword_t addend;

  assign last_step = (step == step_w'(xlen - 1));
  assign addend = mplier[0] ? mcand : '0;

  // iteration control
  always_ff @(posedge clk) begin
    if (reset || flush) begin
      running <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      done <= running & last_step;
      if (start) begin
        running <= 1'b1;
        step <= '0;
      end else if (running) begin
        step <= step + 1'b1;
        if (last_step) running <= 1'b0;
      end
    end
  end

  // datapath, product holds after the last step
  always_ff @(posedge clk) begin
    if (start) begin
      product <= '0;
      if (mode == mul_unsigned_unsigned) begin
        mcand <= {{xlen{1'b0}}, a};
      end else begin
        mcand <= {{xlen{a[xlen-1]}}, a};
      end
      mplier <= b;
      b_signed <= (mode == mul_signed_signed);
    end else if (running) begin
      // signed b has weight -2^31 on its top bit
      if (last_step && b_signed) begin
        product <= product - addend;
      end else begin
        product <= product + addend;
      end
      mcand <= mcand << 1;
      mplier <= mplier >> 1;
    end
  end

endmodule

`default_nettype wire

/* rtl/seq_divider.sv */
// restoring unsigned divider, one quotient bit per cycle
// 32 iterations after start, then a done pulse with quotient and remainder
`default_nettype none

module seq_divider
  import muldiv_pkg::*;
(
  input  logic  clk,
  input  logic  reset,
  input  logic  flush,
  input  logic  start,
  input  word_t dividend,
  input  word_t divisor,
  output word_t quotient,
  output word_t remainder,
  output logic  done
);

  logic running;
  logic [step_w-1:0] step;
  logic last_step;
  word_t dsor;
  // shifted partial remainder minus divisor, top bit is the sign
  logic [xlen:0] trial;

  assign last_step = (step == step_w'(xlen - 1));
  assign trial = {remainder, quotient[xlen-1]} - {1'b0, dsor};

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      running <= 1'b0;
      done <= 1'b0;
      step <= '0;
    end else begin
      done <= running & last_step;
      if (start) begin
        running <= 1'b1;
        step <= '0;
      end else if (running) begin
        step <= step + 1'b1;
        if (last_step) running <= 1'b0;
      end
    end
  end

  // quotient register starts as the dividend and fills from the right
  // zero divisor always subtracts, so q is all ones and r the dividend
  always_ff @(posedge clk) begin
    if (start) begin
      remainder <= '0;
      quotient <= dividend;
      dsor <= divisor;
    end else if (running) begin
      if (!trial[xlen]) begin
        remainder <= trial[xlen-1:0];
        quotient <= {quotient[xlen-2:0], 1'b1};
      end else begin
        // restore, keep the shifted remainder
        remainder <= {remainder[xlen-2:0], quotient[xlen-1]};
        quotient <= {quotient[xlen-2:0], 1'b0};
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/rs_entries.sv */
// entry array of the mul/div reservation station
// issue with operand sourcing, CDB wakeup, rotating pick and pop on done
`default_nettype none

module rs_entries
  import muldiv_pkg::*;
#(
  parameter int rs_index_w = 3,
  parameter int rob_tag_w = 3,
  parameter int cdb_lanes = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  input  logic                 issue,
  input  funct3_t              issue_funct3,
  input  logic                 issue_rs1_regfile_ready,
  input  word_t                issue_rs1_regfile_v,
  input  logic [rob_tag_w-1:0] issue_rs1_tag,
  input  logic                 issue_rs1_rob_ready,
  input  word_t                issue_rs1_rob_v,
  input  logic                 issue_rs2_regfile_ready,
  input  word_t                issue_rs2_regfile_v,
  input  logic [rob_tag_w-1:0] issue_rs2_tag,
  input  logic                 issue_rs2_rob_ready,
  input  word_t                issue_rs2_rob_v,
  input  logic [rob_tag_w-1:0] issue_target_tag,
  input  logic                 cdb_valid [cdb_lanes],
  input  logic [rob_tag_w-1:0] cdb_tag   [cdb_lanes],
  input  word_t                cdb_value [cdb_lanes],
  output logic                 rs_full,
  exec_if.station              ex
);

  localparam int num_entries = 2 ** rs_index_w;

  typedef logic [rob_tag_w-1:0] tag_t;
  typedef logic [rs_index_w-1:0] idx_t;

  // per-entry state
  logic [num_entries-1:0] entry_valid;
  logic [num_entries-1:0] rs1_ready;
  logic [num_entries-1:0] rs2_ready;
  funct3_t entry_funct3 [num_entries];
  word_t rs1_value [num_entries];
  word_t rs2_value [num_entries];
  tag_t rs1_tag [num_entries];
  tag_t rs2_tag [num_entries];
  tag_t target_tag [num_entries];

  // rotation pointer and the entry now in the unit
  idx_t rr_ptr;
  idx_t launch_idx;
  idx_t scan_base;
  idx_t pick_idx;
  idx_t free_idx;
  logic [num_entries-1:0] launchable;
  logic found;
  logic launch;

  // operand values resolved at issue
  logic rs1_cdb_hit;
  logic rs2_cdb_hit;
  word_t rs1_cdb_value;
  word_t rs2_cdb_value;
  logic rs1_in_ready;
  logic rs2_in_ready;
  word_t rs1_in_value;
  word_t rs2_in_value;

  // regfile first, then ROB, then a lane broadcasting this cycle
  function automatic logic [xlen:0] source_op(input logic rf_ready, input word_t rf_v,
                                              input logic rob_ready, input word_t rob_v,
                                              input logic cdb_hit, input word_t cdb_v);
    if (rf_ready) return {1'b1, rf_v};
    if (rob_ready) return {1'b1, rob_v};
    return {cdb_hit, cdb_v};
  endfunction

  // catch a tag that is broadcast in the issue cycle itself
  always_comb begin
    rs1_cdb_hit = 1'b0;
    rs2_cdb_hit = 1'b0;
    rs1_cdb_value = '0;
    rs2_cdb_value = '0;
    for (int j = 0; j < cdb_lanes; j++) begin
      if (cdb_valid[j] && cdb_tag[j] == issue_rs1_tag) begin
        rs1_cdb_hit = 1'b1;
        rs1_cdb_value = cdb_value[j];
      end
      if (cdb_valid[j] && cdb_tag[j] == issue_rs2_tag) begin
        rs2_cdb_hit = 1'b1;
        rs2_cdb_value = cdb_value[j];
      end
    end
  end

  assign {rs1_in_ready, rs1_in_value} = source_op(issue_rs1_regfile_ready, issue_rs1_regfile_v,
                                                  issue_rs1_rob_ready, issue_rs1_rob_v,
                                                  rs1_cdb_hit, rs1_cdb_value);
  assign {rs2_in_ready, rs2_in_value} = source_op(issue_rs2_regfile_ready, issue_rs2_regfile_v,
                                                  issue_rs2_rob_ready, issue_rs2_rob_v,
                                                  rs2_cdb_hit, rs2_cdb_value);

  assign rs_full = &entry_valid;

  // lowest free slot, walk down so the smallest index wins
  always_comb begin
    free_idx = '0;
    for (int i = num_entries - 1; i >= 0; i--) begin
      if (!entry_valid[i]) free_idx = idx_t'(i);
    end
  end

  // entry leaving on done must not be picked again
  always_comb begin
    for (int i = 0; i < num_entries; i++) begin
      launchable[i] = entry_valid[i] & rs1_ready[i] & rs2_ready[i]
                      & ~(ex.done && launch_idx == idx_t'(i));
    end
  end

  // scan starts past the entry popped most recently
  assign scan_base = ex.done ? idx_t'(launch_idx + 1'b1) : rr_ptr;

  always_comb begin
    idx_t cand;
    found = 1'b0;
    pick_idx = scan_base;
    for (int i = 0; i < num_entries; i++) begin
      cand = scan_base + idx_t'(i);
      if (!found && launchable[cand]) begin
        found = 1'b1;
        pick_idx = cand;
      end
    end
  end

  assign launch = found & ~ex.busy;

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      entry_valid <= '0;
      rs1_ready <= '0;
      rs2_ready <= '0;
      rr_ptr <= '0;
      launch_idx <= '0;
      ex.start <= 1'b0;
    end else begin
      ex.start <= launch;
      if (launch) begin
        launch_idx <= pick_idx;
        ex.funct3 <= entry_funct3[pick_idx];
        ex.a <= rs1_value[pick_idx];
        ex.b <= rs2_value[pick_idx];
        ex.tag <= target_tag[pick_idx];
      end
      // snoop all lanes for waiting operands
      for (int i = 0; i < num_entries; i++) begin
        for (int j = 0; j < cdb_lanes; j++) begin
          if (entry_valid[i] && cdb_valid[j] && !rs1_ready[i] && cdb_tag[j] == rs1_tag[i]) begin
            rs1_ready[i] <= 1'b1;
            rs1_value[i] <= cdb_value[j];
          end
          if (entry_valid[i] && cdb_valid[j] && !rs2_ready[i] && cdb_tag[j] == rs2_tag[i]) begin
            rs2_ready[i] <= 1'b1;
            rs2_value[i] <= cdb_value[j];
          end
        end
      end
      // fill the lowest free entry
      if (issue) begin
        entry_valid[free_idx] <= 1'b1;
        entry_funct3[free_idx] <= issue_funct3;
        rs1_ready[free_idx] <= rs1_in_ready;
        rs2_ready[free_idx] <= rs2_in_ready;
        rs1_value[free_idx] <= rs1_in_value;
        rs2_value[free_idx] <= rs2_in_value;
        rs1_tag[free_idx] <= issue_rs1_tag;
        rs2_tag[free_idx] <= issue_rs2_tag;
        target_tag[free_idx] <= issue_target_tag;
      end
      // pop on the result cycle
      if (ex.done) begin
        entry_valid[launch_idx] <= 1'b0;
        rr_ptr <= launch_idx + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

/* rtl/muldiv_exec.sv */
// execution side of the station, one operation in flight
// steers start to the multiplier or divider and drives the result CDB
`default_nettype none

module muldiv_exec
  import muldiv_pkg::*;
#(
  parameter int rob_tag_w = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  exec_if.unit                 ex,
  output logic                 result_valid,
  output logic [rob_tag_w-1:0] result_tag,
  output word_t                result_value
);

  logic busy_q;
  logic mul_start;
  logic div_start;
  logic mul_done;
  logic div_done;
  mul_mode_t mode;
  dword_t product;
  word_t quotient;
  word_t remainder;

  assign mul_start = ex.start & is_mul_op(ex.funct3);
  assign div_start = ex.start & ~is_mul_op(ex.funct3);

  // signedness by funct3, MUL and MULH both signed
  always_comb begin
    case (ex.funct3)
      mulhsu_funct3: mode = mul_signed_unsigned;
      mulhu_funct3:  mode = mul_unsigned_unsigned;
      default:       mode = mul_signed_signed;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      busy_q <= 1'b0;
    end else if (ex.start) begin
      busy_q <= 1'b1;
    end else if (ex.done) begin
      busy_q <= 1'b0;
    end
  end

  // only one unit runs at a time
  assign ex.done = busy_q & (mul_done | div_done);
  // high from the start cycle, low again in the done cycle
  assign ex.busy = ex.start | (busy_q & ~ex.done);

  assign result_valid = ex.done;
  assign result_tag = ex.tag;

  always_comb begin
    case (ex.funct3)
      mul_funct3:  result_value = product[xlen-1:0];
      divu_funct3: result_value = quotient;
      remu_funct3: result_value = remainder;
      // MULH family takes the upper word
      default:     result_value = product[dxlen-1:xlen];
    endcase
  end

  seq_multiplier mul_i (
    .clk    (clk),
    .reset  (reset),
    .flush  (flush),
    .start  (mul_start),
    .mode   (mode),
    .a      (ex.a),
    .b      (ex.b),
    .product(product),
    .done   (mul_done)
  );

  seq_divider div_i (
    .clk      (clk),
    .reset    (reset),
    .flush    (flush),
    .start    (div_start),
    .dividend (ex.a),
    .divisor  (ex.b),
    .quotient (quotient),
    .remainder(remainder),
    .done     (div_done)
  );

endmodule

`default_nettype wire

/* rtl/muldiv_rs.sv */
// top of the mul/div reservation station with plain ports
// entry array launches into the sequential unit over exec_if
`default_nettype none

module muldiv_rs
  import muldiv_pkg::*;
#(
  parameter int rs_index_w = 3,
  parameter int rob_tag_w = 3,
  parameter int cdb_lanes = 3
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 flush,
  // issue from the instruction queue
  input  logic                 issue,
  input  funct3_t              issue_funct3,
  input  logic                 issue_rs1_regfile_ready,
  input  word_t                issue_rs1_regfile_v,
  input  logic [rob_tag_w-1:0] issue_rs1_tag,
  input  logic                 issue_rs1_rob_ready,
  input  word_t                issue_rs1_rob_v,
  input  logic                 issue_rs2_regfile_ready,
  input  word_t                issue_rs2_regfile_v,
  input  logic [rob_tag_w-1:0] issue_rs2_tag,
  input  logic                 issue_rs2_rob_ready,
  input  word_t                issue_rs2_rob_v,
  input  logic [rob_tag_w-1:0] issue_target_tag,
  // snooped CDB lanes
  input  logic                 cdb_valid [cdb_lanes],
  input  logic [rob_tag_w-1:0] cdb_tag   [cdb_lanes],
  input  word_t                cdb_value [cdb_lanes],
  output logic                 rs_full,
  // own CDB output
  output logic                 result_valid,
  output logic [rob_tag_w-1:0] result_tag,
  output word_t                result_value
);

  exec_if #(.rob_tag_w(rob_tag_w)) ex_bus ();

  rs_entries #(
    .rs_index_w(rs_index_w),
    .rob_tag_w (rob_tag_w),
    .cdb_lanes (cdb_lanes)
  ) entries_i (
    .clk                    (clk),
    .reset                  (reset),
    .flush                  (flush),
    .issue                  (issue),
    .issue_funct3           (issue_funct3),
    .issue_rs1_regfile_ready(issue_rs1_regfile_ready),
    .issue_rs1_regfile_v    (issue_rs1_regfile_v),
    .issue_rs1_tag          (issue_rs1_tag),
    .issue_rs1_rob_ready    (issue_rs1_rob_ready),
    .issue_rs1_rob_v        (issue_rs1_rob_v),
    .issue_rs2_regfile_ready(issue_rs2_regfile_ready),
    .issue_rs2_regfile_v    (issue_rs2_regfile_v),
    .issue_rs2_tag          (issue_rs2_tag),
    .issue_rs2_rob_ready    (issue_rs2_rob_ready),
    .issue_rs2_rob_v        (issue_rs2_rob_v),
    .issue_target_tag       (issue_target_tag),
    .cdb_valid              (cdb_valid),
    .cdb_tag                (cdb_tag),
    .cdb_value              (cdb_value),
    .rs_full                (rs_full),
    .ex                     (ex_bus.station)
  );

  muldiv_exec #(
    .rob_tag_w(rob_tag_w)
  ) exec_i (
    .clk         (clk),
    .reset       (reset),
    .flush       (flush),
    .ex          (ex_bus.unit),
    .result_valid(result_valid),
    .result_tag  (result_tag),
    .result_value(result_value)
  );

endmodule

`default_nettype wire

/* testbench/tb_muldiv_rs.sv */
// testbench for the mul/div reservation station
// random issues and CDB wakes, results matched by tag against a model
`default_nettype none

module tb_muldiv_rs
  import muldiv_pkg::*;
();

  localparam int rob_tag_w = 3;
  localparam int cdb_lanes = 3;
  localparam int num_tags = 2 ** rob_tag_w;
  localparam int n_mul = 40;
  localparam int n_div = 40;
  localparam int mix_cycles = 300;
  // every issue slot of every test, mix cycles counted as possible issues
  localparam int max_issues = 4 + n_mul + n_div + 3 + 8 + 8 + 6 + mix_cycles;
  localparam int watchdog_cycles = max_issues * 40 * 8 + 2000;
  // operand source choices at issue
  localparam int src_rf = 0;
  localparam int src_rob = 1;
  localparam int src_both = 2;
  localparam int src_wait = 3;

  typedef logic [rob_tag_w-1:0] tag_t;

  logic clk = 1'b0;
  logic reset;
  logic flush;
  logic issue;
  funct3_t issue_funct3;
  logic issue_rs1_regfile_ready;
  word_t issue_rs1_regfile_v;
  tag_t issue_rs1_tag;
  logic issue_rs1_rob_ready;
  word_t issue_rs1_rob_v;
  logic issue_rs2_regfile_ready;
  word_t issue_rs2_regfile_v;
  tag_t issue_rs2_tag;
  logic issue_rs2_rob_ready;
  word_t issue_rs2_rob_v;
  tag_t issue_target_tag;
  logic cdb_valid [cdb_lanes];
  tag_t cdb_tag [cdb_lanes];
  word_t cdb_value [cdb_lanes];
  logic rs_full;
  logic result_valid;
  tag_t result_tag;
  word_t result_value;

  // model, one record per outstanding target tag
  logic rec_valid [num_tags];
  funct3_t rec_funct3 [num_tags];
  word_t rec_a [num_tags];
  word_t rec_b [num_tags];
  logic rec_a_ready [num_tags];
  logic rec_b_ready [num_tags];
  tag_t rec_a_src [num_tags];
  tag_t rec_b_src [num_tags];
  int outstanding = 0;
  tag_t last_tag;

  // bookkeeping
  int errors = 0;
  int checks = 0;
  int results_seen = 0;
  int issued = 0;
  int flushed = 0;
  int tests_run = 0;
  int tests_failed = 0;

  muldiv_rs #(
    .rs_index_w(3),
    .rob_tag_w (rob_tag_w),
    .cdb_lanes (cdb_lanes)
  ) dut_i (
    .clk                    (clk),
    .reset                  (reset),
    .flush                  (flush),
    .issue                  (issue),
    .issue_funct3           (issue_funct3),
    .issue_rs1_regfile_ready(issue_rs1_regfile_ready),
    .issue_rs1_regfile_v    (issue_rs1_regfile_v),
    .issue_rs1_tag          (issue_rs1_tag),
    .issue_rs1_rob_ready    (issue_rs1_rob_ready),
    .issue_rs1_rob_v        (issue_rs1_rob_v),
    .issue_rs2_regfile_ready(issue_rs2_regfile_ready),
    .issue_rs2_regfile_v    (issue_rs2_regfile_v),
    .issue_rs2_tag          (issue_rs2_tag),
    .issue_rs2_rob_ready    (issue_rs2_rob_ready),
    .issue_rs2_rob_v        (issue_rs2_rob_v),
    .issue_target_tag       (issue_target_tag),
    .cdb_valid              (cdb_valid),
    .cdb_tag                (cdb_tag),
    .cdb_value              (cdb_value),
    .rs_full                (rs_full),
    .result_valid           (result_valid),
    .result_tag             (result_tag),
    .result_value           (result_value)
  );

  always #5 clk = ~clk;

  // RV32M result from the ISA rules, 64-bit wraparound gives the true product
  function automatic word_t expected_result(input funct3_t f, input word_t a, input word_t b);
    dword_t a_s;
    dword_t a_u;
    dword_t b_s;
    dword_t b_u;
    dword_t prod;
    a_s = {{xlen{a[xlen-1]}}, a};
    a_u = {{xlen{1'b0}}, a};
    b_s = {{xlen{b[xlen-1]}}, b};
    b_u = {{xlen{1'b0}}, b};
    if (!is_mul_op(f)) begin
      // zero divisor: quotient all ones, remainder is the dividend
      if (f == remu_funct3) return (b == '0) ? a : a % b;
      return (b == '0) ? '1 : a / b;
    end
    case (f)
      mulh_funct3:   prod = a_s * b_s;
      mulhsu_funct3: prod = a_s * b_u;
      default:       prod = a_u * b_u;
    endcase
    return (f == mul_funct3) ? prod[xlen-1:0] : prod[dxlen-1:xlen];
  endfunction

  // corner operands mixed into random ones
  function automatic word_t rand_word();
    case ($urandom % 8)
      0:       return 32'h8000_0000;
      1:       return '1;
      2:       return '0;
      3:       return 32'h7fff_ffff;
      4:       return 32'h1;
      default: return word_t'($urandom);
    endcase
  endfunction

  function automatic funct3_t random_op();
    case ($urandom % 6)
      0:       return mul_funct3;
      1:       return mulh_funct3;
      2:       return mulhsu_funct3;
      3:       return mulhu_funct3;
      4:       return divu_funct3;
      default: return remu_funct3;
    endcase
  endfunction

  // first free target tag from a random start
  function automatic tag_t free_tag();
    tag_t t;
    t = tag_t'($urandom % num_tags);
    for (int i = 0; i < num_tags; i++) begin
      if (!rec_valid[t]) return t;
      t = t + 1'b1;
    end
    return t;
  endfunction

  // {regfile ready, regfile value, rob ready, rob value}, losing source gets ~v
  function automatic logic [2*xlen+1:0] source_fields(input int src, input word_t v);
    case (src)
      src_rf:   return {1'b1, v, 1'b0, ~v};
      src_rob:  return {1'b0, ~v, 1'b1, v};
      src_both: return {1'b1, v, 1'b1, ~v};
      default:  return {1'b0, ~v, 1'b0, ~v};
    endcase
  endfunction

  // result check against the record of its tag
  task automatic observe();
    tag_t t;
    if (result_valid) begin
      t = result_tag;
      results_seen++;
      checks++;
      if (!rec_valid[t]) begin
        $display("[FAIL] result_tag 0x%h is not outstanding", result_tag);
        errors++;
      end else begin
        if (!(rec_a_ready[t] && rec_b_ready[t])) begin
          $display("result for tag %0d came before its operands were woken", t);
          errors++;
        end else if (result_value !== expected_result(rec_funct3[t], rec_a[t], rec_b[t])) begin
          $display("[FAIL] result_value for tag 0x%h: got 0x%h, expected 0x%h", t,
                   result_value, expected_result(rec_funct3[t], rec_a[t], rec_b[t]));
          errors++;
        end
        rec_valid[t] = 1'b0;
        outstanding--;
      end
    end
  endtask

  // one cycle: falling edge, check outputs, inputs back to idle
  task automatic step();
    @(negedge clk);
    observe();
    issue = 1'b0;
    flush = 1'b0;
    for (int l = 0; l < cdb_lanes; l++) cdb_valid[l] = 1'b0;
  endtask

  task automatic wait_slot();
    step();
    while (rs_full || outstanding >= num_tags) step();
  endtask

  task automatic drive_issue(input funct3_t f, input int src1, input word_t v1, input tag_t s1,
                             input int src2, input word_t v2, input tag_t s2);
    tag_t t;
    t = free_tag();
    last_tag = t;
    issue = 1'b1;
    issue_funct3 = f;
    issue_target_tag = t;
    issue_rs1_tag = s1;
    issue_rs2_tag = s2;
    {issue_rs1_regfile_ready, issue_rs1_regfile_v, issue_rs1_rob_ready, issue_rs1_rob_v} =
      source_fields(src1, v1);
    {issue_rs2_regfile_ready, issue_rs2_regfile_v, issue_rs2_rob_ready, issue_rs2_rob_v} =
      source_fields(src2, v2);
    rec_valid[t] = 1'b1;
    rec_funct3[t] = f;
    rec_a[t] = v1;
    rec_b[t] = v2;
    rec_a_ready[t] = (src1 != src_wait);
    rec_b_ready[t] = (src2 != src_wait);
    rec_a_src[t] = s1;
    rec_b_src[t] = s2;
    outstanding++;
    issued++;
  endtask

  // broadcast on one lane, model wakes every waiting operand on that tag
  task automatic drive_wake(input int lane, input tag_t s, input word_t v);
    cdb_valid[lane] = 1'b1;
    cdb_tag[lane] = s;
    cdb_value[lane] = v;
    for (int i = 0; i < num_tags; i++) begin
      if (rec_valid[i] && !rec_a_ready[i] && rec_a_src[i] == s) begin
        rec_a_ready[i] = 1'b1;
        rec_a[i] = v;
      end
      if (rec_valid[i] && !rec_b_ready[i] && rec_b_src[i] == s) begin
        rec_b_ready[i] = 1'b1;
        rec_b[i] = v;
      end
    end
  endtask

  task automatic wake_all();
    for (int i = 0; i < num_tags; i++) begin
      while (rec_valid[i] && !(rec_a_ready[i] && rec_b_ready[i])) begin
        step();
        if (!rec_a_ready[i]) drive_wake(0, rec_a_src[i], rand_word());
        else drive_wake(0, rec_b_src[i], rand_word());
      end
    end
  endtask

  task automatic drain();
    while (outstanding > 0) step();
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %-10s ok", name);
    end else begin
      tests_failed++;
      $display("test %-10s FAILED with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic check_low(input logic value, input string what);
    checks++;
    if (value !== 1'b0) begin
      $display("[FAIL] %s: got 0x%h, expected 0x0", what, value);
      errors++;
    end
  endtask

  initial begin
    repeat (watchdog_cycles) @(posedge clk);
    $display("timeout: run still busy after %0d cycles", watchdog_cycles);
    $display("Verification failed");
    $finish;
  end

  initial begin
    funct3_t f;
    word_t a;
    word_t b;
    int e0;
    int seen0;
    tag_t s;
    tag_t t3;
    logic [num_tags-1:0] used;
    void'($urandom(32'h3152_1ce1));
    reset = 1'b1;
    flush = 1'b0;
    issue = 1'b0;
    issue_funct3 = '0;
    issue_rs1_regfile_ready = 1'b0;
    issue_rs1_regfile_v = '0;
    issue_rs1_tag = '0;
    issue_rs1_rob_ready = 1'b0;
    issue_rs1_rob_v = '0;
    issue_rs2_regfile_ready = 1'b0;
    issue_rs2_regfile_v = '0;
    issue_rs2_tag = '0;
    issue_rs2_rob_ready = 1'b0;
    issue_rs2_rob_v = '0;
    issue_target_tag = '0;
    for (int l = 0; l < cdb_lanes; l++) begin
      cdb_valid[l] = 1'b0;
      cdb_tag[l] = '0;
      cdb_value[l] = '0;
    end
    for (int i = 0; i < num_tags; i++) rec_valid[i] = 1'b0;
    repeat (2) @(negedge clk);
    reset = 1'b0;

    // station comes out of reset empty and quiet
    e0 = errors;
    step();
    check_low(rs_full, "rs_full after reset");
    check_low(result_valid, "result_valid after reset");
    finish_test("reset", e0);

    // multiplies, corner pair first, operands from the regfile
    e0 = errors;
    for (int i = 0; i < 4; i++) begin
      wait_slot();
      drive_issue(funct3_t'(i), src_rf, 32'h8000_0000, '0, src_rf, '1, '0);
    end
    for (int i = 0; i < n_mul; i++) begin
      wait_slot();
      f = funct3_t'($urandom % 4);
      drive_issue(f, src_rf, rand_word(), '0, src_rf, rand_word(), '0);
    end
    drain();
    finish_test("multiply", e0);

    // divides with zero divisors and small dividends
    e0 = errors;
    for (int i = 0; i < n_div; i++) begin
      wait_slot();
      f = ($urandom % 2 == 0) ? divu_funct3 : remu_funct3;
      a = rand_word();
      b = rand_word();
      case ($urandom % 4)
        0: b = '0;
        1: begin
          b = b | 32'h0001_0000;
          a = a % b;
        end
        default: ;
      endcase
      drive_issue(f, src_rf, a, '0, src_rf, b, '0);
    end
    drain();
    finish_test("divide", e0);

    // regfile beats ROB, ROB alone, then a CDB wake
    e0 = errors;
    wait_slot();
    drive_issue(mul_funct3, src_both, rand_word(), '0, src_both, rand_word(), '0);
    wait_slot();
    drive_issue(divu_funct3, src_rob, rand_word(), '0, src_rob, rand_word(), '0);
    wait_slot();
    drive_issue(mulhu_funct3, src_wait, '0, 3'd5, src_both, rand_word(), '0);
    t3 = last_tag;
    repeat (80) step();
    checks++;
    if (!rec_valid[t3]) begin
      $display("waiting instruction left the station without a wake");
      errors++;
    end
    drive_wake(2, 3'd5, rand_word());
    drain();
    finish_test("sources", e0);

    // eight waiting entries fill the station, one wake frees one entry
    e0 = errors;
    for (int i = 0; i < num_tags; i++) begin
      wait_slot();
      drive_issue(random_op(), src_wait, '0, tag_t'(i), src_wait, '0, tag_t'(i));
    end
    step();
    checks++;
    if (rs_full !== 1'b1) begin
      $display("[FAIL] rs_full with eight entries waiting: got 0x%h, expected 0x1", rs_full);
      errors++;
    end
    seen0 = results_seen;
    drive_wake(1, 3'd3, rand_word());
    repeat (80) step();
    checks++;
    if (results_seen - seen0 != 1) begin
      $display("one wake gave %0d results instead of one", results_seen - seen0);
      errors++;
    end
    check_low(rs_full, "rs_full after one pop");
    wake_all();
    drain();
    finish_test("full", e0);

    // flush with one operation in flight and the rest waiting
    e0 = errors;
    for (int i = 0; i < num_tags; i++) begin
      wait_slot();
      drive_issue(random_op(), (i < 2) ? src_rf : src_wait, rand_word(), tag_t'(i),
                  (i < 2) ? src_rf : src_wait, rand_word(), tag_t'(i));
    end
    repeat (6) step();
    flush = 1'b1;
    flushed += outstanding;
    outstanding = 0;
    for (int i = 0; i < num_tags; i++) rec_valid[i] = 1'b0;
    step();
    check_low(rs_full, "rs_full after flush");
    seen0 = results_seen;
    // wakes now hit no entry
    for (int i = 0; i < num_tags; i++) begin
      step();
      drive_wake(i % cdb_lanes, tag_t'(i), rand_word());
    end
    repeat (80) step();
    checks++;
    if (results_seen != seen0) begin
      $display("%0d results appeared after the flush", results_seen - seen0);
      errors++;
    end
    for (int i = 0; i < 6; i++) begin
      wait_slot();
      drive_issue(random_op(), int'($urandom % 4), rand_word(), tag_t'($urandom % num_tags),
                  int'($urandom % 4), rand_word(), tag_t'($urandom % num_tags));
    end
    wake_all();
    drain();
    finish_test("flush", e0);

    // long random mix of issues, wakes and idle cycles
    e0 = errors;
    for (int c = 0; c < mix_cycles; c++) begin
      step();
      case ($urandom % 4)
        0: begin
          if (!rs_full && outstanding < num_tags) begin
            drive_issue(random_op(), int'($urandom % 4), rand_word(),
                        tag_t'($urandom % num_tags), int'($urandom % 4), rand_word(),
                        tag_t'($urandom % num_tags));
          end
        end
        1: begin
          // distinct tags across lanes in one cycle
          used = '0;
          for (int l = 0; l < cdb_lanes; l++) begin
            s = tag_t'($urandom % num_tags);
            if (!used[s] && $urandom % 2 == 0) begin
              used[s] = 1'b1;
              drive_wake(l, s, rand_word());
            end
          end
        end
        default: ;
      endcase
    end
    wake_all();
    drain();
    repeat (40) step();
    checks++;
    if (results_seen != issued - flushed) begin
      $display("[FAIL] result count: got 0x%h, expected 0x%h", results_seen, issued - flushed);
      errors++;
    end
    finish_test("mix", e0);

    $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d results",
             tests_run, tests_failed, checks, errors, results_seen);
    if (errors == 0 && tests_failed == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
rtl/muldiv_pkg.sv
rtl/exec_if.sv
rtl/seq_multiplier.sv
rtl/seq_divider.sv
rtl/rs_entries.sv
rtl/muldiv_exec.sv
rtl/muldiv_rs.sv
testbench/tb_muldiv_rs.sv

/* Makefile */
TOP = tb_muldiv_rs

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f flist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed$$"

clean:
	rm -rf obj_dir
